//--- Bender.yml
package:
  name: ooo_dispatch

sources:
  - include_dirs:
      - src
    files:
      - src/ooo_pkg.sv
      - src/dispatch_rob_if.sv
      - src/dispatch.sv
      - src/rob_alloc.sv
      - src/busy_table.sv
      - src/issue_queue.sv
      - src/dispatch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/dispatch_tb.sv

//--- bench/dispatch_tb.sv
`default_nettype none

`include "ooo_config.svh"

module dispatch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS = `OOO_ROB_ROWS;

    logic                 clk;
    logic                 rst_n;
    ooo_pkg::uop_bundle_t uop_0;
    ooo_pkg::uop_bundle_t uop_1;
    logic                 pause_req;
    logic                 retire;
    logic                 wb_valid;
    ooo_pkg::preg_t       wb_preg;
    logic                 alu_issue_valid;
    ooo_pkg::alu_entry_t  alu_issue_entry;
    logic                 alu_issue_ready;
    logic                 lsu_issue_valid;
    ooo_pkg::lsu_entry_t  lsu_issue_entry;
    logic                 lsu_issue_ready;
    logic                 mdu_issue_valid;
    ooo_pkg::mdu_entry_t  mdu_issue_entry;
    logic                 mdu_issue_ready;

    // values the next cycle drives
    ooo_pkg::uop_bundle_t cur0;
    ooo_pkg::uop_bundle_t cur1;
    logic                 drv_retire;
    logic                 drv_wb;
    ooo_pkg::preg_t       drv_wb_preg;
    logic                 rdy_alu;
    logic                 rdy_lsu;
    logic                 rdy_mdu;
    logic                 accepted;

    // reference model state
    ooo_pkg::alu_entry_t  alu_q[$];
    ooo_pkg::lsu_entry_t  lsu_q[$];
    ooo_pkg::mdu_entry_t  mdu_q[$];
    int                   m_rows;
    logic [ooo_pkg::ROW_W-1:0] m_tail;
    logic [`OOO_PRF_REGS-1:0]  m_busy;

    dispatch_top dispatch_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .uop_0(uop_0),
        .uop_1(uop_1),
        .pause_req(pause_req),
        .retire(retire),
        .wb_valid(wb_valid),
        .wb_preg(wb_preg),
        .alu_issue_valid(alu_issue_valid),
        .alu_issue_entry(alu_issue_entry),
        .alu_issue_ready(alu_issue_ready),
        .lsu_issue_valid(lsu_issue_valid),
        .lsu_issue_entry(lsu_issue_entry),
        .lsu_issue_ready(lsu_issue_ready),
        .mdu_issue_valid(mdu_issue_valid),
        .mdu_issue_entry(mdu_issue_entry),
        .mdu_issue_ready(mdu_issue_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("error %s expected %h actual %h", name, exp, act);
        $display("Done: errors found");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_with(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "check failed");
    endtask

    function automatic logic store_op(input ooo_pkg::uop_e u);
        return u inside {ooo_pkg::SB_U, ooo_pkg::SH_U, ooo_pkg::SW_U,
                         ooo_pkg::SWL_U, ooo_pkg::SWR_U};
    endfunction

    function automatic logic mul_op(input ooo_pkg::uop_e u);
        return u inside {ooo_pkg::MULTHI_U, ooo_pkg::MULTLO_U,
                         ooo_pkg::MULTUHI_U, ooo_pkg::MULTULO_U};
    endfunction

    // queue class of each op code
    function automatic ooo_pkg::rs_e class_of(input ooo_pkg::uop_e u);
        if (mul_op(u) || u == ooo_pkg::DIV_U || u == ooo_pkg::DIVU_U) begin
            return ooo_pkg::RS_MDU;
        end
        if (store_op(u) || u inside {ooo_pkg::LB_U, ooo_pkg::LBU_U, ooo_pkg::LH_U,
                                     ooo_pkg::LHU_U, ooo_pkg::LW_U}) begin
            return ooo_pkg::RS_LSU;
        end
        return ooo_pkg::RS_ALU;
    endfunction

    function automatic ooo_pkg::uop_bundle_t mk(input ooo_pkg::uop_e op,
                                                input int l0, input int p0,
                                                input int l1, input int p1,
                                                input int pd, input logic we);
        ooo_pkg::uop_bundle_t u;
        u = '0;
        u.valid     = 1'b1;
        u.uop       = op;
        u.rs_type   = class_of(op);
        u.op0_laddr = ooo_pkg::lreg_t'(l0);
        u.op1_laddr = ooo_pkg::lreg_t'(l1);
        u.op0_re    = 1'b1;
        u.op1_re    = 1'b1;
        u.op0_paddr = ooo_pkg::preg_t'(p0);
        u.op1_paddr = ooo_pkg::preg_t'(p1);
        u.dst_paddr = ooo_pkg::preg_t'(pd);
        u.dst_we    = we;
        return u;
    endfunction

    // expected id is 2r or 2r+1, busy only for real ops
    function automatic ooo_pkg::uop_bundle_t tag(input ooo_pkg::uop_bundle_t u,
                                                 input logic slot);
        ooo_pkg::uop_bundle_t t;
        t      = u;
        t.id   = {m_tail, slot};
        t.busy = u.valid && u.uop != ooo_pkg::NOP_U && u.uop != ooo_pkg::MDBUBBLE_U;
        return t;
    endfunction

    function automatic logic src_rdy(input logic re, input ooo_pkg::lreg_t l,
                                     input ooo_pkg::preg_t p);
        return !re || l == 0 || !m_busy[p];
    endfunction

    // one clock of drive, port checks and model update
    task automatic cycle();
        ooo_pkg::uop_bundle_t t0;
        ooo_pkg::uop_bundle_t t1;
        ooo_pkg::arb_info_t   r0;
        ooo_pkg::arb_info_t   r1;
        ooo_pkg::alu_entry_t  ae;
        ooo_pkg::lsu_entry_t  le;
        ooo_pkg::mdu_entry_t  me;
        logic                 exp_pause;
        logic                 dep;
        logic [`OOO_PRF_REGS-1:0] nb;
        @(posedge clk);
        #1;
        uop_0           = cur0;
        uop_1           = cur1;
        retire          = drv_retire;
        wb_valid        = drv_wb;
        wb_preg         = drv_wb_preg;
        alu_issue_ready = rdy_alu;
        lsu_issue_ready = rdy_lsu;
        mdu_issue_ready = rdy_mdu;
        #1;
        exp_pause = (m_rows == ROWS) || (alu_q.size() > `OOO_ALU_DEPTH - 2) ||
                    (lsu_q.size() > `OOO_LSU_DEPTH - 2) ||
                    (mdu_q.size() > `OOO_MDU_DEPTH - 2);
        assert (pause_req === exp_pause)
            else report_mismatch("pause_req", exp_pause, pause_req);
        // issue_valid tracks model occupancy
        assert (alu_issue_valid === (alu_q.size() != 0))
            else abort_with("alu issue_valid disagrees with the model queue");
        assert (lsu_issue_valid === (lsu_q.size() != 0))
            else abort_with("lsu issue_valid disagrees with the model queue");
        assert (mdu_issue_valid === (mdu_q.size() != 0))
            else abort_with("mdu issue_valid disagrees with the model queue");
        if (alu_issue_valid && rdy_alu) begin
            assert (alu_issue_entry === alu_q[0])
                else report_mismatch("alu issue", alu_q[0], alu_issue_entry);
            void'(alu_q.pop_front());
        end
        if (lsu_issue_valid && rdy_lsu) begin
            assert (lsu_issue_entry === lsu_q[0])
                else report_mismatch("lsu issue", lsu_q[0], lsu_issue_entry);
            void'(lsu_q.pop_front());
        end
        if (mdu_issue_valid && rdy_mdu) begin
            assert (mdu_issue_entry === mdu_q[0])
                else report_mismatch("mdu issue", mdu_q[0], mdu_issue_entry);
            void'(mdu_q.pop_front());
        end
        accepted = !exp_pause;
        nb = m_busy;
        if (drv_wb) begin
            nb[drv_wb_preg] = 1'b0;
        end
        // retire sees the occupancy from before this edge
        if (drv_retire && m_rows > 0) begin
            m_rows = m_rows - 1;
        end
        if (accepted) begin
            t0 = tag(cur0, 1'b0);
            t1 = tag(cur1, 1'b1);
            r0.prs1_rdy = src_rdy(cur0.op0_re, cur0.op0_laddr, cur0.op0_paddr);
            r0.prs2_rdy = src_rdy(cur0.op1_re, cur0.op1_laddr, cur0.op1_paddr);
            r1.prs1_rdy = src_rdy(cur1.op0_re, cur1.op0_laddr, cur1.op0_paddr);
            r1.prs2_rdy = src_rdy(cur1.op1_re, cur1.op1_laddr, cur1.op1_paddr);
            // slot 1 reading what slot 0 writes in the same pair
            dep = cur0.valid && cur0.dst_we;
            if (dep && cur1.op0_re && cur1.op0_laddr != 0 &&
                cur1.op0_paddr == cur0.dst_paddr) begin
                r1.prs1_rdy = 1'b0;
            end
            if (dep && cur1.op1_re && cur1.op1_laddr != 0 &&
                cur1.op1_paddr == cur0.dst_paddr) begin
                r1.prs2_rdy = 1'b0;
            end
            // pushing in slot order gives the compaction rule
            if (cur0.valid && cur0.rs_type == ooo_pkg::RS_ALU) begin
                ae.ops  = t0;
                ae.rdys = r0;
                alu_q.push_back(ae);
            end
            if (cur1.valid && cur1.rs_type == ooo_pkg::RS_ALU) begin
                ae.ops  = t1;
                ae.rdys = r1;
                alu_q.push_back(ae);
            end
            if (cur0.valid && cur0.rs_type == ooo_pkg::RS_LSU) begin
                le.ops      = t0;
                le.rdys     = r0;
                le.is_store = store_op(cur0.uop);
                lsu_q.push_back(le);
            end
            if (cur1.valid && cur1.rs_type == ooo_pkg::RS_LSU) begin
                le.ops      = t1;
                le.rdys     = r1;
                le.is_store = store_op(cur1.uop);
                lsu_q.push_back(le);
            end
            if (cur0.valid && cur0.rs_type == ooo_pkg::RS_MDU) begin
                me.ops_hi = t0;
                me.ops_lo = t1;
                me.rdys   = r0;
                me.is_mul = mul_op(cur0.uop);
                mdu_q.push_back(me);
            end
            if (cur0.valid || cur1.valid) begin
                m_rows = m_rows + 1;
                m_tail = m_tail + 1'b1;
            end
            if (cur0.valid && cur0.dst_we) begin
                nb[cur0.dst_paddr] = 1'b1;
            end
            if (cur1.valid && cur1.dst_we) begin
                nb[cur1.dst_paddr] = 1'b1;
            end
        end
        nb[0] = 1'b0;
        m_busy = nb;
        // one-cycle strobes
        drv_retire = 1'b0;
        drv_wb     = 1'b0;
    endtask

    // hold the pair until it is taken
    task automatic send_pair(input ooo_pkg::uop_bundle_t a, input ooo_pkg::uop_bundle_t b);
        int n;
        cur0 = a;
        cur1 = b;
        n = 0;
        cycle();
        while (!accepted && n < 200) begin
            n++;
            cycle();
        end
        if (!accepted) begin
            abort_with("timeout waiting for a pair to be accepted");
        end
        cur0 = '0;
        cur1 = '0;
    endtask

    task automatic drain_all();
        int n;
        rdy_alu = 1'b1;
        rdy_lsu = 1'b1;
        rdy_mdu = 1'b1;
        n = 0;
        while ((alu_q.size() + lsu_q.size() + mdu_q.size()) != 0 && n < 200) begin
            n++;
            cycle();
        end
        if (n >= 200) begin
            abort_with("timeout waiting for the issue queues to drain");
        end
        cycle();
    endtask

    task automatic free_rows();
        int n;
        n = 0;
        while (m_rows != 0 && n < 200) begin
            n++;
            drv_retire = 1'b1;
            cycle();
        end
        if (m_rows != 0) begin
            abort_with("timeout waiting for rob rows to retire");
        end
    endtask

    initial begin
        ooo_pkg::uop_bundle_t a;
        ooo_pkg::uop_bundle_t b;
        void'($urandom(32'ha072));
        rst_n = 1'b0;
        uop_0 = '0;
        uop_1 = '0;
        retire = 1'b0;
        wb_valid = 1'b0;
        wb_preg = '0;
        alu_issue_ready = 1'b0;
        lsu_issue_ready = 1'b0;
        mdu_issue_ready = 1'b0;
        cur0 = '0;
        cur1 = '0;
        drv_retire = 1'b0;
        drv_wb = 1'b0;
        drv_wb_preg = '0;
        rdy_alu = 1'b1;
        rdy_lsu = 1'b1;
        rdy_mdu = 1'b1;
        m_rows = 0;
        m_tail = '0;
        m_busy = '0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        cycle();

        // alu pairs, a lone slot 1 op, nop and bubble, an idle pair
        send_pair(mk(ooo_pkg::ADDU_U, 1, 1, 2, 2, 10, 1),
                  mk(ooo_pkg::SUBU_U, 3, 3, 4, 4, 11, 1));
        a = mk(ooo_pkg::LW_U, 1, 1, 0, 0, 12, 1);
        send_pair(a, mk(ooo_pkg::OR_U, 5, 5, 6, 6, 13, 1));
        send_pair(mk(ooo_pkg::NOP_U, 0, 0, 0, 0, 0, 0),
                  mk(ooo_pkg::MDBUBBLE_U, 0, 0, 0, 0, 0, 0));
        b = mk(ooo_pkg::XOR_U, 7, 7, 8, 8, 14, 1);
        b.valid = 1'b0;
        send_pair(b, b);
        // mdu hi/lo pairs for mult and divide
        send_pair(mk(ooo_pkg::MULTHI_U, 2, 2, 3, 3, 15, 1),
                  mk(ooo_pkg::MULTLO_U, 2, 2, 3, 3, 16, 1));
        send_pair(mk(ooo_pkg::DIVU_U, 2, 2, 3, 3, 17, 1),
                  mk(ooo_pkg::DIV_U, 2, 2, 3, 3, 18, 1));
        // lsu stores and loads and a lone lsu op in slot 1
        send_pair(mk(ooo_pkg::SW_U, 1, 1, 2, 2, 0, 0),
                  mk(ooo_pkg::LBU_U, 3, 3, 0, 0, 19, 1));
        send_pair(mk(ooo_pkg::AND_U, 1, 1, 2, 2, 20, 1),
                  mk(ooo_pkg::SWR_U, 3, 3, 4, 4, 0, 0));
        // readiness of a busy source, $zero and a same-pair dependence
        send_pair(mk(ooo_pkg::ADDU_U, 1, 1, 2, 2, 30, 1),
                  mk(ooo_pkg::SLT_U, 9, 30, 0, 30, 31, 1));
        send_pair(mk(ooo_pkg::OR_U, 4, 30, 5, 31, 32, 1),
                  mk(ooo_pkg::AND_U, 6, 32, 7, 1, 33, 1));
        drv_wb = 1'b1;
        drv_wb_preg = 30;
        cycle();
        send_pair(mk(ooo_pkg::OR_U, 4, 30, 0, 31, 34, 1), b);
        drain_all();
        free_rows();

        // rob fills with retire low
        // a lone alu op per pair keeps the queues shallow
        for (int i = 0; i < ROWS; i++) begin
            send_pair(mk(ooo_pkg::SLL_U, 1, 1, 2, 2, 40, 1), b);
        end
        cur0 = mk(ooo_pkg::SRL_U, 1, 1, 2, 2, 41, 1);
        repeat (4) cycle();
        drv_retire = 1'b1;
        send_pair(cur0, b);
        free_rows();

        // alu queue stalls with issue_ready low
        rdy_alu = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_pair(mk(ooo_pkg::ADDU_U, 1, 1, 2, 2, 42, 1),
                      mk(ooo_pkg::SUBU_U, 1, 1, 2, 2, 43, 1));
        end
        cur0 = mk(ooo_pkg::ADDU_U, 1, 1, 2, 2, 44, 1);
        repeat (4) cycle();
        rdy_alu = 1'b1;
        send_pair(cur0, b);
        drain_all();
        free_rows();

        // random pairs with random drains, retire and writeback
        accepted = 1'b1;
        for (int i = 0; i < 400; i++) begin
            if (accepted) begin
                a = mk(ooo_pkg::uop_e'($urandom_range(0, 26)), $urandom_range(0, 31),
                       $urandom_range(0, 63), $urandom_range(0, 31), $urandom_range(0, 63),
                       $urandom_range(0, 63), $urandom_range(0, 1));
                b = mk(ooo_pkg::uop_e'($urandom_range(0, 26)), $urandom_range(0, 31),
                       $urandom_range(0, 63), $urandom_range(0, 31), $urandom_range(0, 63),
                       $urandom_range(0, 63), $urandom_range(0, 1));
                a.valid  = ($urandom_range(0, 7) != 0);
                b.valid  = ($urandom_range(0, 7) != 0);
                a.op1_re = $urandom_range(0, 1);
                b.op0_re = $urandom_range(0, 1);
                // mdu only from slot 0
                if (b.rs_type == ooo_pkg::RS_MDU && a.rs_type != ooo_pkg::RS_MDU) begin
                    b.uop     = ooo_pkg::ADDU_U;
                    b.rs_type = ooo_pkg::RS_ALU;
                end
                cur0 = a;
                cur1 = b;
            end
            rdy_alu     = $urandom_range(0, 3) != 0;
            rdy_lsu     = $urandom_range(0, 1);
            rdy_mdu     = $urandom_range(0, 2) == 0;
            drv_retire  = $urandom_range(0, 1);
            drv_wb      = $urandom_range(0, 1);
            drv_wb_preg = ooo_pkg::preg_t'($urandom_range(0, 63));
            cycle();
        end
        cur0 = '0;
        cur1 = '0;
        drain_all();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/ooo_pkg.sv
src/dispatch_rob_if.sv
src/dispatch.sv
src/rob_alloc.sv
src/busy_table.sv
src/issue_queue.sv
src/dispatch_top.sv
bench/dispatch_tb.sv

//--- src/busy_table.sv
`default_nettype none

`include "ooo_config.svh"

module busy_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ooo_pkg::preg_t [3:0] rd_addr,
    output logic [3:0]           busy_rd,
    input  logic                 set_en_0,
    input  logic                 set_en_1,
    input  ooo_pkg::preg_t       set_addr_0,
    input  ooo_pkg::preg_t       set_addr_1,
    input  logic                 clr_en,
    input  ooo_pkg::preg_t       clr_addr
);

    localparam int REGS = `OOO_PRF_REGS;

    logic [REGS-1:0] busy;
    logic [REGS-1:0] busy_next;

    // clear first so a set on the same edge wins
    always_comb begin
        busy_next = busy;
        if (clr_en) begin
            busy_next[clr_addr] = 1'b0;
        end
        if (set_en_0) begin
            busy_next[set_addr_0] = 1'b1;
        end
        if (set_en_1) begin
            busy_next[set_addr_1] = 1'b1;
        end
        // $zero never waits
        busy_next[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    // no bypass, a set shows up after its edge
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            busy_rd[i] = busy[rd_addr[i]];
        end
    end

endmodule

`default_nettype wire

//--- src/dispatch.sv
`default_nettype none

module dispatch (
    dispatch_rob_if.dispatch    rob,
    input  ooo_pkg::uop_bundle_t uop_0,
    input  ooo_pkg::uop_bundle_t uop_1,
    input  logic [3:0]           busy_rd,
    output ooo_pkg::preg_t [3:0] rd_addr,
    output logic                 set_en_0,
    output logic                 set_en_1,
    output ooo_pkg::preg_t       set_addr_0,
    output ooo_pkg::preg_t       set_addr_1,
    input  logic                 alu_can_two,
    input  logic                 lsu_can_two,
    input  logic                 mdu_can_two,
    output logic                 alu_wen_0,
    output logic                 alu_wen_1,
    output logic                 lsu_wen_0,
    output logic                 lsu_wen_1,
    output logic                 mdu_wen,
    output ooo_pkg::alu_entry_t  alu_dout_0,
    output ooo_pkg::alu_entry_t  alu_dout_1,
    output ooo_pkg::lsu_entry_t  lsu_dout_0,
    output ooo_pkg::lsu_entry_t  lsu_dout_1,
    output ooo_pkg::mdu_entry_t  mdu_dout,
    output logic                 pause_req
);

    ooo_pkg::uop_bundle_t slot_0;
    ooo_pkg::uop_bundle_t slot_1;
    ooo_pkg::arb_info_t   rdy_0;
    ooo_pkg::arb_info_t   rdy_1;
    logic                 accept;
    logic                 alu_0;
    logic                 alu_1;
    logic                 lsu_0;
    logic                 lsu_1;
    logic                 mdu_0;
    logic [3:0]           src_wait;
    logic                 slot0_writes;
    logic                 raw_a;
    logic                 raw_b;

    // ops that occupy a rob slot for real
    function automatic logic is_real(input ooo_pkg::uop_bundle_t u);
        return u.valid && (u.uop != ooo_pkg::NOP_U) && (u.uop != ooo_pkg::MDBUBBLE_U);
    endfunction

    function automatic logic is_store(input ooo_pkg::uop_e u);
        return (u == ooo_pkg::SB_U) || (u == ooo_pkg::SH_U) || (u == ooo_pkg::SW_U) ||
               (u == ooo_pkg::SWL_U) || (u == ooo_pkg::SWR_U);
    endfunction

    function automatic logic is_mul(input ooo_pkg::uop_e u);
        return (u == ooo_pkg::MULTHI_U) || (u == ooo_pkg::MULTLO_U) ||
               (u == ooo_pkg::MULTUHI_U) || (u == ooo_pkg::MULTULO_U);
    endfunction

    // stall on full rob or any queue short of two free entries
    assign pause_req = ~rob.ready | ~alu_can_two | ~lsu_can_two | ~mdu_can_two;
    assign accept    = ~pause_req;

    // slot ids are 2r and 2r+1
    always_comb begin
        slot_0      = uop_0;
        slot_0.id   = {rob.row_id, 1'b0};
        slot_0.busy = is_real(uop_0);
        slot_1      = uop_1;
        slot_1.id   = {rob.row_id, 1'b1};
        slot_1.busy = is_real(uop_1);
    end

    assign rob.uop0  = slot_0;
    assign rob.uop1  = slot_1;
    // no row for an all-invalid pair
    assign rob.valid = (uop_0.valid | uop_1.valid) & accept;

    // scoreboard busy marking
    assign set_en_0   = accept & uop_0.valid & uop_0.dst_we;
    assign set_en_1   = accept & uop_1.valid & uop_1.dst_we;
    assign set_addr_0 = uop_0.dst_paddr;
    assign set_addr_1 = uop_1.dst_paddr;

    // scoreboard lookups, slot 0 first
    assign rd_addr[0] = uop_0.op0_paddr;
    assign rd_addr[1] = uop_0.op1_paddr;
    assign rd_addr[2] = uop_1.op0_paddr;
    assign rd_addr[3] = uop_1.op1_paddr;

    // sources that really read a register, $zero excluded
    assign src_wait[0] = uop_0.op0_re & (|uop_0.op0_laddr);
    assign src_wait[1] = uop_0.op1_re & (|uop_0.op1_laddr);
    assign src_wait[2] = uop_1.op0_re & (|uop_1.op0_laddr);
    assign src_wait[3] = uop_1.op1_re & (|uop_1.op1_laddr);

    // slot 1 reading the destination slot 0 writes in this pair
    assign slot0_writes = uop_0.valid & uop_0.dst_we;
    assign raw_a = slot0_writes & (uop_1.op0_paddr == uop_0.dst_paddr);
    assign raw_b = slot0_writes & (uop_1.op1_paddr == uop_0.dst_paddr);

    assign rdy_0.prs1_rdy = ~src_wait[0] | ~busy_rd[0];
    assign rdy_0.prs2_rdy = ~src_wait[1] | ~busy_rd[1];
    assign rdy_1.prs1_rdy = ~src_wait[2] | (~busy_rd[2] & ~raw_a);
    assign rdy_1.prs2_rdy = ~src_wait[3] | (~busy_rd[3] & ~raw_b);

    // class decode
    assign alu_0 = uop_0.valid & (uop_0.rs_type == ooo_pkg::RS_ALU);
    assign alu_1 = uop_1.valid & (uop_1.rs_type == ooo_pkg::RS_ALU);
    assign lsu_0 = uop_0.valid & (uop_0.rs_type == ooo_pkg::RS_LSU);
    assign lsu_1 = uop_1.valid & (uop_1.rs_type == ooo_pkg::RS_LSU);
    // only slot 0 may carry an mdu op
    assign mdu_0 = uop_0.valid & (uop_0.rs_type == ooo_pkg::RS_MDU);

    // a lone op always lands on port 0
    assign alu_wen_0 = accept & (alu_0 | alu_1);
    assign alu_wen_1 = accept & alu_0 & alu_1;
    assign lsu_wen_0 = accept & (lsu_0 | lsu_1);
    assign lsu_wen_1 = accept & lsu_0 & lsu_1;
    assign mdu_wen   = accept & mdu_0;

    always_comb begin
        alu_dout_0.ops       = alu_0 ? slot_0 : slot_1;
        alu_dout_0.rdys      = alu_0 ? rdy_0 : rdy_1;
        alu_dout_1.ops       = slot_1;
        alu_dout_1.rdys      = rdy_1;
        lsu_dout_0.ops       = lsu_0 ? slot_0 : slot_1;
        lsu_dout_0.rdys      = lsu_0 ? rdy_0 : rdy_1;
        lsu_dout_0.is_store  = lsu_0 ? is_store(uop_0.uop) : is_store(uop_1.uop);
        lsu_dout_1.ops       = slot_1;
        lsu_dout_1.rdys      = rdy_1;
        lsu_dout_1.is_store  = is_store(uop_1.uop);
        // hi half in slot 0, lo half in slot 1
        mdu_dout.ops_hi      = slot_0;
        mdu_dout.ops_lo      = slot_1;
        mdu_dout.rdys        = rdy_0;
        mdu_dout.is_mul      = is_mul(uop_0.uop);
    end

endmodule

`default_nettype wire

//--- src/dispatch_rob_if.sv
`default_nettype none

interface dispatch_rob_if;

    // tagged micro-op pair
    ooo_pkg::uop_bundle_t uop0;
    ooo_pkg::uop_bundle_t uop1;
    // allocate one row this edge
    logic                 valid;
    // next free row
    logic [ooo_pkg::ROW_W-1:0] row_id;
    // at least one row free
    logic                 ready;

    modport dispatch (output uop0, output uop1, output valid, input row_id, input ready);

    modport rob (input uop0, input uop1, input valid, output row_id, output ready);

endinterface

`default_nettype wire

//--- src/dispatch_top.sv
`default_nettype none

`include "ooo_config.svh"

module dispatch_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ooo_pkg::uop_bundle_t uop_0,
    input  ooo_pkg::uop_bundle_t uop_1,
    output logic                 pause_req,
    input  logic                 retire,
    input  logic                 wb_valid,
    input  ooo_pkg::preg_t       wb_preg,
    output logic                 alu_issue_valid,
    output ooo_pkg::alu_entry_t  alu_issue_entry,
    input  logic                 alu_issue_ready,
    output logic                 lsu_issue_valid,
    output ooo_pkg::lsu_entry_t  lsu_issue_entry,
    input  logic                 lsu_issue_ready,
    output logic                 mdu_issue_valid,
    output ooo_pkg::mdu_entry_t  mdu_issue_entry,
    input  logic                 mdu_issue_ready
);

    dispatch_rob_if rob_bus ();

    // scoreboard traffic
    ooo_pkg::preg_t [3:0] rd_addr;
    logic [3:0]           busy_rd;
    logic                 set_en_0;
    logic                 set_en_1;
    ooo_pkg::preg_t       set_addr_0;
    ooo_pkg::preg_t       set_addr_1;

    // queue write side
    logic                 alu_can_two;
    logic                 lsu_can_two;
    logic                 mdu_can_two;
    logic                 alu_wen_0;
    logic                 alu_wen_1;
    logic                 lsu_wen_0;
    logic                 lsu_wen_1;
    logic                 mdu_wen;
    ooo_pkg::alu_entry_t  alu_dout_0;
    ooo_pkg::alu_entry_t  alu_dout_1;
    ooo_pkg::lsu_entry_t  lsu_dout_0;
    ooo_pkg::lsu_entry_t  lsu_dout_1;
    ooo_pkg::mdu_entry_t  mdu_dout;

    dispatch dispatch_inst (
        .rob(rob_bus),
        .uop_0(uop_0),
        .uop_1(uop_1),
        .busy_rd(busy_rd),
        .rd_addr(rd_addr),
        .set_en_0(set_en_0),
        .set_en_1(set_en_1),
        .set_addr_0(set_addr_0),
        .set_addr_1(set_addr_1),
        .alu_can_two(alu_can_two),
        .lsu_can_two(lsu_can_two),
        .mdu_can_two(mdu_can_two),
        .alu_wen_0(alu_wen_0),
        .alu_wen_1(alu_wen_1),
        .lsu_wen_0(lsu_wen_0),
        .lsu_wen_1(lsu_wen_1),
        .mdu_wen(mdu_wen),
        .alu_dout_0(alu_dout_0),
        .alu_dout_1(alu_dout_1),
        .lsu_dout_0(lsu_dout_0),
        .lsu_dout_1(lsu_dout_1),
        .mdu_dout(mdu_dout),
        .pause_req(pause_req)
    );

    rob_alloc rob_alloc_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rob(rob_bus),
        .retire(retire)
    );

    // writeback clears the busy bit
    busy_table busy_table_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr(rd_addr),
        .busy_rd(busy_rd),
        .set_en_0(set_en_0),
        .set_en_1(set_en_1),
        .set_addr_0(set_addr_0),
        .set_addr_1(set_addr_1),
        .clr_en(wb_valid),
        .clr_addr(wb_preg)
    );

    issue_queue #(
        .entry_t(ooo_pkg::alu_entry_t),
        .DEPTH(`OOO_ALU_DEPTH)
    ) alu_queue_inst (
        .clk(clk),
        .rst_n(rst_n),
        .wen_0(alu_wen_0),
        .wen_1(alu_wen_1),
        .din_0(alu_dout_0),
        .din_1(alu_dout_1),
        .can_accept_two(alu_can_two),
        .issue_valid(alu_issue_valid),
        .issue_entry(alu_issue_entry),
        .issue_ready(alu_issue_ready)
    );

    issue_queue #(
        .entry_t(ooo_pkg::lsu_entry_t),
        .DEPTH(`OOO_LSU_DEPTH)
    ) lsu_queue_inst (
        .clk(clk),
        .rst_n(rst_n),
        .wen_0(lsu_wen_0),
        .wen_1(lsu_wen_1),
        .din_0(lsu_dout_0),
        .din_1(lsu_dout_1),
        .can_accept_two(lsu_can_two),
        .issue_valid(lsu_issue_valid),
        .issue_entry(lsu_issue_entry),
        .issue_ready(lsu_issue_ready)
    );

    // one hi/lo entry per pair, second port idle
    issue_queue #(
        .entry_t(ooo_pkg::mdu_entry_t),
        .DEPTH(`OOO_MDU_DEPTH)
    ) mdu_queue_inst (
        .clk(clk),
        .rst_n(rst_n),
        .wen_0(mdu_wen),
        .wen_1(1'b0),
        .din_0(mdu_dout),
        .din_1('0),
        .can_accept_two(mdu_can_two),
        .issue_valid(mdu_issue_valid),
        .issue_entry(mdu_issue_entry),
        .issue_ready(mdu_issue_ready)
    );

endmodule

`default_nettype wire

//--- src/issue_queue.sv
`default_nettype none

module issue_queue #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wen_0,
    input  logic   wen_1,
    input  entry_t din_0,
    input  entry_t din_1,
    output logic   can_accept_two,
    output logic   issue_valid,
    output entry_t issue_entry,
    input  logic   issue_ready
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    entry_t        mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;
    logic [1:0]    n_wr;

    // pointer advance with wrap for any depth
    function automatic logic [PW-1:0] ptr_add(input logic [PW-1:0] p, input int n);
        int s;
        s = int'(p) + n;
        if (s >= DEPTH) begin
            s = s - DEPTH;
        end
        return PW'(s);
    endfunction

    assign issue_valid    = (count != '0);
    assign issue_entry    = mem[rd_ptr];
    assign pop            = issue_valid & issue_ready;
    assign can_accept_two = (int'(count) + 2) <= DEPTH;
    // wen_1 only comes with wen_0
    assign n_wr           = {1'b0, wen_0} + {1'b0, wen_1};

    // payload storage, din_0 goes in first
    always_ff @(posedge clk) begin
        if (wen_0) begin
            mem[wr_ptr] <= din_0;
        end
        if (wen_1) begin
            mem[ptr_add(wr_ptr, 1)] <= din_1;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, int'(n_wr));
            if (pop) begin
                rd_ptr <= ptr_add(rd_ptr, 1);
            end
            count <= count + CW'(n_wr) - CW'(pop);
        end
    end

endmodule

`default_nettype wire

//--- src/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// rob rows, two slots per row
// 64 rows give a 6 bit row id and a 7 bit slot id
`define OOO_ROB_ROWS 64

// physical register file size
`define OOO_PRF_REGS 64

// issue queue depths
`define OOO_ALU_DEPTH 8
`define OOO_LSU_DEPTH 8
`define OOO_MDU_DEPTH 4

`endif

//--- src/ooo_pkg.sv
`default_nettype none

`include "ooo_config.svh"

package ooo_pkg;

    // widths derived from the config header
    localparam int ROW_W  = $clog2(`OOO_ROB_ROWS);
    localparam int PREG_W = $clog2(`OOO_PRF_REGS);

    // micro-op codes
    typedef enum logic [5:0] {
        NOP_U, MDBUBBLE_U,
        MULTHI_U, MULTLO_U, MULTUHI_U, MULTULO_U,
        DIV_U, DIVU_U,
        SB_U, SH_U, SW_U, SWL_U, SWR_U,
        LB_U, LBU_U, LH_U, LHU_U, LW_U,
        ADDU_U, SUBU_U, AND_U, OR_U, XOR_U, SLT_U, SLTU_U, SLL_U, SRL_U
    } uop_e;

    // target issue queue
    typedef enum logic [1:0] {
        RS_ALU,
        RS_LSU,
        RS_MDU
    } rs_e;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [4:0]        lreg_t;

    // row number, then the slot bit
    typedef logic [ROW_W:0] rob_id_t;

    typedef struct packed {
        logic    valid;
        uop_e    uop;
        rs_e     rs_type;
        lreg_t   op0_laddr;
        lreg_t   op1_laddr;
        logic    op0_re;
        logic    op1_re;
        preg_t   op0_paddr;
        preg_t   op1_paddr;
        preg_t   dst_paddr;
        logic    dst_we;
        rob_id_t id;
        logic    busy;
    } uop_bundle_t;

    // source readiness at dispatch time
    typedef struct packed {
        logic prs1_rdy;
        logic prs2_rdy;
    } arb_info_t;

    typedef struct packed {
        uop_bundle_t ops;
        arb_info_t   rdys;
    } alu_entry_t;

    typedef struct packed {
        uop_bundle_t ops;
        arb_info_t   rdys;
        logic        is_store;
    } lsu_entry_t;

    // hi/lo pair, both slots of one row
    typedef struct packed {
        uop_bundle_t ops_hi;
        uop_bundle_t ops_lo;
        arb_info_t   rdys;
        logic        is_mul;
    } mdu_entry_t;

endpackage

`default_nettype wire

//--- src/rob_alloc.sv
`default_nettype none

`include "ooo_config.svh"

module rob_alloc (
    input  logic       clk,
    input  logic       rst_n,
    dispatch_rob_if.rob rob,
    input  logic       retire
);

    localparam int ROWS = `OOO_ROB_ROWS;
    localparam int RW   = ooo_pkg::ROW_W;

    logic [RW-1:0] tail;
    logic [RW:0]   count;
    logic          do_alloc;
    logic          do_retire;

    // dispatch only raises valid while a row is free
    assign do_alloc  = rob.valid;
    // retire on an empty rob is dropped
    assign do_retire = retire && (count != '0);

    assign rob.row_id = tail;
    assign rob.ready  = (count != (RW + 1)'(ROWS));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail  <= '0;
            count <= '0;
        end else begin
            // new row at the tail
            if (do_alloc) begin
                tail <= (tail == RW'(ROWS - 1)) ? '0 : tail + 1'b1;
            end
            // oldest row leaves on retire
            case ({do_alloc, do_retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
